//--- include/detlat_macros.svh
/*
  detlat widths and constants
  sizes the FIFO words, pointers, read start gap and phase accumulator
*/
`ifndef DETLAT_MACROS_SVH
`define DETLAT_MACROS_SVH

// one transceiver word per FIFO entry
`define DETLAT_DATA_WIDTH 80

// 16 words deep, pointers carry one extra wrap bit
`define DETLAT_ADDR_WIDTH 4

// rd_clk cycles the read side waits after reset before popping
`define DETLAT_PTR_GAP 6

// phase accumulator and sample size input widths
`define DETLAT_ACC_WIDTH 32
`define DETLAT_SAMPLE_WIDTH 8

`endif

//--- verilog/detlat_pkg.sv
/*
  detlat shared types
  word, pointer, accumulator and sample count types for the
  deterministic latency FIFO and its phase calculator
*/
`include "detlat_macros.svh"

package detlat_pkg;

  // one FIFO entry as pushed by the write domain
  typedef logic [`DETLAT_DATA_WIDTH-1:0] data_t;

  // binary or Gray pointer, also used for occupancy counts
  // the top bit is the wrap bit that tells full from empty
  typedef logic [`DETLAT_ADDR_WIDTH:0] ptr_t;

  // running sum of pointer differences in calc_clk
  typedef logic [`DETLAT_ACC_WIDTH-1:0] acc_t;

  // number of samples that make up one accumulation window
  typedef logic [`DETLAT_SAMPLE_WIDTH-1:0] sample_t;

endpackage

//--- verilog/detlat_gray_sync.sv
/*
  Gray pointer synchronizer
  two flop crossing of a Gray coded pointer into the clk domain,
  with the synchronized value also given back in binary
*/
`timescale 1ns/10ps

module detlat_gray_sync (
  input  logic              clk,
  input  logic              rst,
  input  detlat_pkg::ptr_t  gray_in,
  output detlat_pkg::ptr_t  gray_out,
  output detlat_pkg::ptr_t  bin_out
);

  // first stage may go metastable, only the second stage is consumed
  detlat_pkg::ptr_t meta_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      meta_q   <= '0;
      gray_out <= '0;
    end
    else
    begin
      meta_q   <= gray_in;
      gray_out <= meta_q;
    end
  end

  // each binary bit is the xor of all Gray bits at or above it
  always_comb
  begin
    for (int i = 0; i < $bits(detlat_pkg::ptr_t); i++)
    begin
      bin_out[i] = ^(gray_out >> i);
    end
  end

endmodule

//--- verilog/detlat_dcfifo.sv
/*
  dual clock FIFO with deterministic read start
  writes every wr_clk cycle unless full, starts reading a fixed gap
  after rd reset and reports occupancy in both clock domains
*/
`timescale 1ns/10ps
`include "detlat_macros.svh"

module detlat_dcfifo (
  input  logic               wr_clk,
  input  logic               rst_wr,
  input  detlat_pkg::data_t  wr_data,
  output logic               wr_full,
  output detlat_pkg::ptr_t   fifo_wr_latency,
  output detlat_pkg::ptr_t   gray_wr_ptr,
  input  logic               rd_clk,
  input  logic               rst_rd,
  output detlat_pkg::data_t  rd_data,
  output logic               rd_empty,
  output detlat_pkg::ptr_t   fifo_rd_latency,
  output detlat_pkg::ptr_t   gray_rd_ptr
);

  // the storage is written in wr_clk and read in rd_clk
  detlat_pkg::data_t mem [0:(1 << `DETLAT_ADDR_WIDTH)-1];

  logic             wr_en;
  detlat_pkg::ptr_t wr_ptr_bin;
  detlat_pkg::ptr_t wr_ptr_next;
  detlat_pkg::ptr_t wr_gray_next;
  detlat_pkg::ptr_t rd_gray_wsync;
  detlat_pkg::ptr_t rd_bin_wsync;

  logic [`DETLAT_PTR_GAP-1:0] rd_start_sr;
  logic             rd_start;
  logic             rd_en;
  detlat_pkg::ptr_t rd_ptr_bin;
  detlat_pkg::ptr_t rd_ptr_next;
  detlat_pkg::ptr_t rd_gray_next;
  detlat_pkg::ptr_t wr_gray_rsync;
  detlat_pkg::ptr_t wr_bin_rsync;

  // the write side pushes on every cycle out of reset, full words are dropped
  assign wr_en        = !rst_wr && !wr_full;
  assign wr_ptr_next  = wr_ptr_bin + detlat_pkg::ptr_t'(wr_en);
  assign wr_gray_next = wr_ptr_next ^ (wr_ptr_next >> 1);

  always_ff @(posedge wr_clk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr_bin[`DETLAT_ADDR_WIDTH-1:0]] <= wr_data;
    end
  end

  // full is looked ahead from the next pointer so the flag lines up with it
  // a full Gray pointer differs from the read one only in the two top bits
  always_ff @(posedge wr_clk or posedge rst_wr)
  begin
    if (rst_wr)
    begin
      wr_ptr_bin      <= '0;
      gray_wr_ptr     <= '0;
      wr_full         <= 1'b0;
      fifo_wr_latency <= '0;
    end
    else
    begin
      wr_ptr_bin      <= wr_ptr_next;
      gray_wr_ptr     <= wr_gray_next;
      wr_full         <= (wr_gray_next == {~rd_gray_wsync[`DETLAT_ADDR_WIDTH -: 2],
                                           rd_gray_wsync[`DETLAT_ADDR_WIDTH-2:0]});
      fifo_wr_latency <= wr_ptr_next - rd_bin_wsync;
    end
  end

  // read pointer as seen from the write domain
  detlat_gray_sync u_rd_ptr_sync (
    .clk      (wr_clk),
    .rst      (rst_wr),
    .gray_in  (gray_rd_ptr),
    .gray_out (rd_gray_wsync),
    .bin_out  (rd_bin_wsync)
  );

  // write pointer as seen from the read domain
  detlat_gray_sync u_wr_ptr_sync (
    .clk      (rd_clk),
    .rst      (rst_rd),
    .gray_in  (gray_wr_ptr),
    .gray_out (wr_gray_rsync),
    .bin_out  (wr_bin_rsync)
  );

  // a one walks up the shift register after reset, so reading starts
  // exactly DETLAT_PTR_GAP edges later and the pointers keep a fixed gap
  always_ff @(posedge rd_clk or posedge rst_rd)
  begin
    if (rst_rd)
    begin
      rd_start_sr <= '0;
    end
    else
    begin
      rd_start_sr <= {rd_start_sr[`DETLAT_PTR_GAP-2:0], 1'b1};
    end
  end

  assign rd_start     = rd_start_sr[`DETLAT_PTR_GAP-1];
  assign rd_en        = rd_start && !rd_empty;
  assign rd_ptr_next  = rd_ptr_bin + detlat_pkg::ptr_t'(rd_en);
  assign rd_gray_next = rd_ptr_next ^ (rd_ptr_next >> 1);

  // the head word is always presented as a show ahead output
  assign rd_data = mem[rd_ptr_bin[`DETLAT_ADDR_WIDTH-1:0]];

  always_ff @(posedge rd_clk or posedge rst_rd)
  begin
    if (rst_rd)
    begin
      rd_ptr_bin      <= '0;
      gray_rd_ptr     <= '0;
      rd_empty        <= 1'b1;
      fifo_rd_latency <= '0;
    end
    else
    begin
      rd_ptr_bin      <= rd_ptr_next;
      gray_rd_ptr     <= rd_gray_next;
      rd_empty        <= (rd_gray_next == wr_gray_rsync);
      fifo_rd_latency <= wr_bin_rsync - rd_ptr_next;
    end
  end

  // the write pointer holds on the edge after full was seen
  a_no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (rst_wr)
    wr_full |=> $stable(wr_ptr_bin));

  // the read pointer holds on the edge after empty was seen
  a_no_read_when_empty: assert property (
    @(posedge rd_clk) disable iff (rst_rd)
    rd_empty |=> $stable(rd_ptr_bin));

  // the exported pointer must be safe to synchronize in any clock domain
  a_gray_one_bit: assert property (
    @(posedge wr_clk) disable iff (rst_wr)
    $countones(gray_wr_ptr ^ $past(gray_wr_ptr)) <= 1);

endmodule

//--- verilog/detlat_ph_calc.sv
/*
  phase accumulator
  samples both FIFO pointers in calc_clk and sums their distance over
  a programmable window, then publishes the sum with a valid strobe
*/
`timescale 1ns/10ps

module detlat_ph_calc (
  input  logic                 calc_clk,
  input  logic                 rst_calc,
  input  detlat_pkg::ptr_t     gray_wr_ptr,
  input  detlat_pkg::ptr_t     gray_rd_ptr,
  input  detlat_pkg::sample_t  fifo_sample_size,
  output detlat_pkg::acc_t     phase_measure_acc,
  output logic                 ph_acc_valid
);

  detlat_pkg::ptr_t    wr_bin;
  detlat_pkg::ptr_t    rd_bin;
  detlat_pkg::ptr_t    ptr_diff;
  detlat_pkg::acc_t    acc_sum;
  detlat_pkg::acc_t    acc_next;
  detlat_pkg::sample_t sample_cnt;
  logic                window_end;

  // both pointers are unrelated to calc_clk so each needs its own crossing
  detlat_gray_sync u_wr_sync (
    .clk      (calc_clk),
    .rst      (rst_calc),
    .gray_in  (gray_wr_ptr),
    .gray_out (),
    .bin_out  (wr_bin)
  );

  detlat_gray_sync u_rd_sync (
    .clk      (calc_clk),
    .rst      (rst_calc),
    .gray_in  (gray_rd_ptr),
    .gray_out (),
    .bin_out  (rd_bin)
  );

  // the pointer width wraps naturally, giving the modulo 32 distance
  assign ptr_diff = wr_bin - rd_bin;
  assign acc_next = acc_sum + detlat_pkg::acc_t'(ptr_diff);

  // greater or equal so a window shrunk mid count still closes
  assign window_end = (sample_cnt >= fifo_sample_size - 1'b1);

  always_ff @(posedge calc_clk or posedge rst_calc)
  begin
    if (rst_calc)
    begin
      acc_sum           <= '0;
      sample_cnt        <= '0;
      phase_measure_acc <= '0;
      ph_acc_valid      <= 1'b0;
    end
    else if (fifo_sample_size == '0)
    begin
      // a zero window parks the block with nothing accumulated
      acc_sum      <= '0;
      sample_cnt   <= '0;
      ph_acc_valid <= 1'b0;
    end
    else if (window_end)
    begin
      // the last sample goes straight into the published result
      phase_measure_acc <= acc_next;
      ph_acc_valid      <= 1'b1;
      acc_sum           <= '0;
      sample_cnt        <= '0;
    end
    else
    begin
      acc_sum      <= acc_next;
      sample_cnt   <= sample_cnt + 1'b1;
      ph_acc_valid <= 1'b0;
    end
  end

  // a window longer than one sample cannot close on two edges in a row
  a_valid_single_pulse: assert property (
    @(posedge calc_clk) disable iff (rst_calc)
    (ph_acc_valid && fifo_sample_size > 8'd1) |=> !ph_acc_valid);

endmodule

//--- verilog/detlat_ph_measure_fifo.sv
/*
  deterministic latency phase measuring FIFO
  the dual clock FIFO feeds its Gray pointers to the phase accumulator
*/
`timescale 1ns/10ps

module detlat_ph_measure_fifo (
  input  logic                 rd_clk,
  input  logic                 wr_clk,
  input  logic                 calc_clk,
  input  logic                 rst_rd,
  input  logic                 rst_wr,
  input  logic                 rst_calc,
  input  detlat_pkg::data_t    wr_data,
  input  detlat_pkg::sample_t  fifo_sample_size,
  output detlat_pkg::data_t    rd_data,
  output detlat_pkg::acc_t     phase_measure_acc,
  output detlat_pkg::ptr_t     fifo_wr_latency,
  output detlat_pkg::ptr_t     fifo_rd_latency,
  output logic                 ph_acc_valid,
  output logic                 wr_full,
  output logic                 rd_empty
);

  // raw Gray pointers, registered inside the FIFO in their own domains
  detlat_pkg::ptr_t gray_wr_ptr;
  detlat_pkg::ptr_t gray_rd_ptr;

  detlat_dcfifo u_fifo (
    .wr_clk          (wr_clk),
    .rst_wr          (rst_wr),
    .wr_data         (wr_data),
    .wr_full         (wr_full),
    .fifo_wr_latency (fifo_wr_latency),
    .gray_wr_ptr     (gray_wr_ptr),
    .rd_clk          (rd_clk),
    .rst_rd          (rst_rd),
    .rd_data         (rd_data),
    .rd_empty        (rd_empty),
    .fifo_rd_latency (fifo_rd_latency),
    .gray_rd_ptr     (gray_rd_ptr)
  );

  detlat_ph_calc u_ph_calc (
    .calc_clk          (calc_clk),
    .rst_calc          (rst_calc),
    .gray_wr_ptr       (gray_wr_ptr),
    .gray_rd_ptr       (gray_rd_ptr),
    .fifo_sample_size  (fifo_sample_size),
    .phase_measure_acc (phase_measure_acc),
    .ph_acc_valid      (ph_acc_valid)
  );

endmodule

//--- tb/detlat_tb.sv
/*
  testbench for the deterministic latency phase measuring FIFO
  streams LFSR words through the FIFO, checks order, read start, occupancy
  and the phase accumulator windows against a queue model
*/
`timescale 1ns/10ps
`include "detlat_macros.svh"

module detlat_tb;

  logic                rd_clk;
  logic                wr_clk;
  logic                calc_clk;
  logic                rst_rd;
  logic                rst_wr;
  logic                rst_calc;
  detlat_pkg::data_t   wr_data;
  detlat_pkg::sample_t fifo_sample_size;
  detlat_pkg::data_t   rd_data;
  detlat_pkg::acc_t    phase_measure_acc;
  detlat_pkg::ptr_t    fifo_wr_latency;
  detlat_pkg::ptr_t    fifo_rd_latency;
  logic                ph_acc_valid;
  logic                wr_full;
  logic                rd_empty;

  // model state with the words in flight and the counters per clock domain
  detlat_pkg::data_t model_q[$];
  logic [15:0]       lfsr_state;
  logic              read_started;
  int                pops;
  int                rd_edges;
  int                pulse_count;
  int                calc_cycle;
  int                last_pulse;
  int                idle_pulses;

  detlat_ph_measure_fifo uut (
    .rd_clk            (rd_clk),
    .wr_clk            (wr_clk),
    .calc_clk          (calc_clk),
    .rst_rd            (rst_rd),
    .rst_wr            (rst_wr),
    .rst_calc          (rst_calc),
    .wr_data           (wr_data),
    .fifo_sample_size  (fifo_sample_size),
    .rd_data           (rd_data),
    .phase_measure_acc (phase_measure_acc),
    .fifo_wr_latency   (fifo_wr_latency),
    .fifo_rd_latency   (fifo_rd_latency),
    .ph_acc_valid      (ph_acc_valid),
    .wr_full           (wr_full),
    .rd_empty          (rd_empty)
  );

  // the write clock runs at the read rate with a fixed phase offset
  initial
  begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;
  end

  initial
  begin
    wr_clk = 1'b0;
    #1.3;
    forever #2 wr_clk = ~wr_clk;
  end

  initial
  begin
    calc_clk = 1'b0;
    forever #1.85 calc_clk = ~calc_clk;
  end

  // 16 bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one LFSR step for every bit of the word
  function automatic detlat_pkg::data_t random_word();
    detlat_pkg::data_t w;
    for (int i = 0; i < $bits(detlat_pkg::data_t); i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i] = lfsr_state[0];
    end
    return w;
  endfunction

  task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                             input string msg);
    if (actual !== expected)
    begin
      $display("ERROR at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped at the first mismatch");
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped on a timeout");
  endtask

  // polls after the edge so the monitor count is already settled
  task automatic wait_for_pulse(input int limit, input string what);
    int start;
    int waited;
    start = pulse_count;
    waited = 0;
    while (pulse_count == start && waited < limit)
    begin
      @(posedge calc_clk);
      #0.5;
      waited++;
    end
    if (pulse_count == start)
      abort_on_timeout(what);
  endtask

  // a new word is presented shortly after every write edge
  always @(posedge wr_clk)
  begin
    #0.5;
    wr_data = random_word();
  end

  // equal clock rates must never fill the FIFO and every accepted word enters the model
  always @(posedge wr_clk)
  begin
    if (!rst_wr)
    begin
      check_equal(wr_full, 1'b0, "wr_full rose although both clocks run at one rate");
      if (!wr_full)
        model_q.push_back(wr_data);
      if (read_started)
        check_equal(fifo_wr_latency >= 1 && fifo_wr_latency <= 16, 1'b1,
                    $sformatf("fifo_wr_latency %0d outside 1 to 16", fifo_wr_latency));
    end
  end

  // the head word is shown ahead, and only popped once the start gap is over
  always @(posedge rd_clk)
  begin
    if (!rst_rd)
    begin
      if (read_started)
        check_equal(fifo_rd_latency >= 1 && fifo_rd_latency <= 16, 1'b1,
                    $sformatf("fifo_rd_latency %0d outside 1 to 16", fifo_rd_latency));
      if (!rd_empty)
      begin
        check_equal(model_q.size() > 0, 1'b1, "read side not empty but nothing was written");
        check_equal(rd_data, model_q[0], "rd_data differs from the oldest written word");
        if (rd_edges >= `DETLAT_PTR_GAP)
        begin
          void'(model_q.pop_front());
          pops++;
          read_started = 1'b1;
        end
      end
      rd_edges++;
    end
  end

  // window spacing and the range of every published sum
  always @(posedge calc_clk)
  begin
    if (!rst_calc)
    begin
      calc_cycle++;
      if (ph_acc_valid)
      begin
        check_equal(fifo_sample_size != 0, 1'b1, "ph_acc_valid pulsed with sample size zero");
        check_equal(phase_measure_acc <= 16 * int'(fifo_sample_size), 1'b1,
                    $sformatf("phase_measure_acc %0d above 16 per sample", phase_measure_acc));
        if (pulse_count > 0)
        begin
          check_equal(calc_cycle - last_pulse, fifo_sample_size, "pulse spacing in calc_clk");
          check_equal(phase_measure_acc >= (`DETLAT_PTR_GAP - 3) * int'(fifo_sample_size) &&
                      phase_measure_acc <= (`DETLAT_PTR_GAP + 3) * int'(fifo_sample_size),
                      1'b1, $sformatf("steady phase_measure_acc %0d", phase_measure_acc));
        end
        last_pulse = calc_cycle;
        pulse_count++;
      end
    end
  end

  initial
  begin
    int waited;
    rst_rd = 1'b1;
    rst_wr = 1'b1;
    rst_calc = 1'b1;
    wr_data = '0;
    fifo_sample_size = 8'd16;
    lfsr_state = 16'd30;
    read_started = 1'b0;
    pops = 0;
    rd_edges = 0;
    pulse_count = 0;
    calc_cycle = 0;
    last_pulse = 0;
    repeat (2) @(posedge rd_clk);
    #0.5;
    check_equal(rd_empty, 1'b1, "rd_empty in reset");
    check_equal(wr_full, 1'b0, "wr_full in reset");
    check_equal(ph_acc_valid, 1'b0, "ph_acc_valid in reset");
    check_equal(phase_measure_acc, '0, "phase_measure_acc in reset");
    rst_rd = 1'b0;
    rst_wr = 1'b0;
    rst_calc = 1'b0;
    // the first pop lands right after the start gap
    waited = 0;
    while (pops == 0 && waited < 40)
    begin
      @(posedge rd_clk);
      #0.5;
      waited++;
    end
    if (pops == 0)
      abort_on_timeout("no word was read after the start gap");
    for (int i = 0; i < 4; i++)
      wait_for_pulse(40, "no ph_acc_valid pulse with sample size 16");
    // switched right after a pulse so the next window is a full one
    fifo_sample_size = 8'd37;
    for (int i = 0; i < 3; i++)
      wait_for_pulse(90, "no ph_acc_valid pulse with sample size 37");
    fifo_sample_size = 8'd0;
    idle_pulses = pulse_count;
    repeat (100) @(posedge calc_clk);
    #0.5;
    check_equal(pulse_count, idle_pulses, "pulse count while the window is zero");
    check_equal(pops > 100, 1'b1, $sformatf("only %0d words read", pops));
    $display("PASS: all tests");
    $finish;
  end

  // last resort if a loop above never returns
  initial
  begin
    #5000;
    $display("timeout: the simulation ran past its time limit");
    $display("FAIL: see errors above");
    $fatal(1, "run stopped by the watchdog");
  end

endmodule

//--- detlat.f
+incdir+include
verilog/detlat_pkg.sv
verilog/detlat_gray_sync.sv
verilog/detlat_dcfifo.sv
verilog/detlat_ph_calc.sv
verilog/detlat_ph_measure_fifo.sv
tb/detlat_tb.sv

//--- Bender.yml
package:
  name: detlat

export_include_dirs:
  - include

sources:
  # synthesizable design, package first
  - files:
      - verilog/detlat_pkg.sv
      - verilog/detlat_gray_sync.sv
      - verilog/detlat_dcfifo.sv
      - verilog/detlat_ph_calc.sv
      - verilog/detlat_ph_measure_fifo.sv

  # self-checking testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/detlat_tb.sv
